/* hw/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	////////////////////
	// Layer geometry
	localparam int img_width  = 8;
	localparam int img_size   = img_width * img_width;
	localparam int ch_in      = 4;
	localparam int ch_out     = 4;
	localparam int fmap_words = ch_in * img_size;
	localparam int gap_cycles = 4;

	// Partial sums are split into an even and an odd pixel bank
	localparam int psum_depth = img_size / 2;

	////////////////////
	// Payload and index types
	typedef logic signed [7:0]  pixel_t;
	typedef logic signed [7:0]  weight_t;
	typedef logic signed [19:0] acc_t;

	typedef logic [$clog2(img_size)-1:0]   pix_idx_t;
	typedef logic [$clog2(ch_in)-1:0]      ich_t;
	typedef logic [$clog2(ch_out)-1:0]     och_t;
	typedef logic [$clog2(fmap_words)-1:0] fmap_addr_t;

	// Host weight write, 12 bits
	typedef struct packed {
		och_t    och;
		ich_t    ich;
		weight_t value;
	} weight_wr_t;

	// One output pixel, 28 bits
	typedef struct packed {
		och_t     och;
		pix_idx_t pix;
		acc_t     value;
	} result_t;

endpackage

`default_nettype wire

/* hw/fmap_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module fmap_ram #(
	parameter type word_t = logic [7:0],
	parameter int  depth  = 256
) (
	input  wire                     clk,
	input  wire                     en,
	input  wire                     we,
	input  wire [$clog2(depth)-1:0] addr,
	input  wire word_t              wdata,
	output word_t                   rdata
);

	word_t mem [depth];

	// Single port, registered read, old data on a write
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

/* hw/fmap_replay.sv */
`timescale 1ns/1ps
`default_nettype none

module fmap_replay import conv_pkg::*; (
	input  wire         clk,
	input  wire         reset,
	input  wire         pxl_valid,
	input  wire pixel_t pxl_in,
	output logic        rp_valid,
	output pixel_t      rp_pixel,
	output logic        rp_first,
	output logic        busy
);

	typedef enum logic [1:0] {st_idle, st_write, st_replay, st_gap} state_t;

	state_t     state;
	fmap_addr_t wr_addr;
	fmap_addr_t rd_addr;
	och_t       pass_cnt;
	logic [$clog2(gap_cycles)-1:0] gap_cnt;

	logic       pxl_valid_q;
	pixel_t     pxl_q;
	logic       mem_en;
	logic       mem_we;
	fmap_addr_t mem_addr;
	pixel_t     mem_rdata;
	logic       rd_issue;
	logic       rd_issue_q;
	logic       first_q;
	logic [1:0] tail_q;

	////////////////////
	// Input register
	always_ff @(posedge clk) begin
		if (reset) begin
			pxl_valid_q <= 1'b0;
		end else begin
			pxl_valid_q <= pxl_valid && (state == st_idle || state == st_write);
		end
	end

	always_ff @(posedge clk) begin
		pxl_q <= pxl_in;
	end

	////////////////////
	// Write, replay and gap sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= st_idle;
			wr_addr  <= '0;
			rd_addr  <= '0;
			pass_cnt <= '0;
			gap_cnt  <= '0;
		end else begin
			case (state)
				st_idle: begin
					wr_addr  <= '0;
					pass_cnt <= '0;
					if (pxl_valid) begin
						state <= st_write;
					end
				end
				st_write: begin
					if (pxl_valid_q) begin
						wr_addr <= wr_addr + 1'b1;
						// Last word written, first read follows next cycle
						if (wr_addr == fmap_addr_t'(fmap_words - 1)) begin
							rd_addr <= '0;
							state   <= st_replay;
						end
					end
				end
				st_replay: begin
					rd_addr <= rd_addr + 1'b1;
					if (rd_addr == fmap_addr_t'(fmap_words - 1)) begin
						gap_cnt <= '0;
						if (pass_cnt == och_t'(ch_out - 1)) begin
							state <= st_idle;
						end else begin
							pass_cnt <= pass_cnt + 1'b1;
							state    <= st_gap;
						end
					end
				end
				st_gap: begin
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_cnt == ($bits(gap_cnt))'(gap_cycles - 1)) begin
						rd_addr <= '0;
						state   <= st_replay;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign rd_issue = (state == st_replay);
	assign mem_en   = rd_issue || (state == st_write && pxl_valid_q);
	assign mem_we   = (state == st_write);
	assign mem_addr = rd_issue ? rd_addr : wr_addr;

	fmap_ram #(
		.word_t(pixel_t),
		.depth (fmap_words)
	) fmap_ram_i (
		.clk  (clk),
		.en   (mem_en),
		.we   (mem_we),
		.addr (mem_addr),
		.wdata(pxl_q),
		.rdata(mem_rdata)
	);

	////////////////////
	// Output delay matching the memory read
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_issue_q <= 1'b0;
			first_q    <= 1'b0;
			rp_valid   <= 1'b0;
			rp_first   <= 1'b0;
			tail_q     <= '0;
		end else begin
			rd_issue_q <= rd_issue;
			first_q    <= rd_issue && (rd_addr == '0);
			rp_valid   <= rd_issue_q;
			rp_first   <= first_q;
			// Covers the two accumulator stages after the last replayed word
			tail_q     <= {tail_q[0], rp_valid};
		end
	end

	always_ff @(posedge clk) begin
		rp_pixel <= mem_rdata;
	end

	assign busy = (state != st_idle) || rd_issue_q || rp_valid || (|tail_q);

endmodule

`default_nettype wire

/* hw/weight_store.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_store import conv_pkg::*; (
	input  wire             clk,
	input  wire             reset,
	input  wire             wr_req,
	input  wire weight_wr_t wr_data,
	output logic            wr_ack,
	input  wire och_t       w_och,
	input  wire ich_t       w_ich,
	output weight_t         w_value
);

	weight_t weights [ch_out][ch_in];

	logic req_rise;

	////////////////////
	// Four-phase slave

	// Ack is req delayed by one cycle, so req high with ack low is the request edge
	assign req_rise = wr_req && !wr_ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ack <= 1'b0;
		end else begin
			wr_ack <= wr_req;
		end
	end

	// One entry per handshake
	always_ff @(posedge clk) begin
		if (req_rise) begin
			weights[wr_data.och][wr_data.ich] <= wr_data.value;
		end
	end

	////////////////////
	// Lookup for the accumulator
	assign w_value = weights[w_och][w_ich];

endmodule

`default_nettype wire

/* hw/pointwise_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module pointwise_accum import conv_pkg::*; (
	input  wire         clk,
	input  wire         reset,
	input  wire         rp_valid,
	input  wire pixel_t rp_pixel,
	input  wire         rp_first,
	output och_t        w_och,
	output ich_t        w_ich,
	input  wire weight_t w_value,
	output logic        res_valid,
	output result_t     res
);

	typedef logic [$clog2(psum_depth)-1:0] bank_addr_t;

	logic     frame_active;
	pix_idx_t pix_cnt;
	ich_t     ich_cnt;
	och_t     och_cnt;
	pix_idx_t cur_pix;
	ich_t     cur_ich;
	och_t     cur_och;
	acc_t     prod;

	logic     s1_valid;
	pix_idx_t s1_pix;
	ich_t     s1_ich;
	och_t     s1_och;
	acc_t     s1_prod;
	acc_t     psum_rd;
	acc_t     sum;
	logic     s2_write;

	logic       bank_en    [2];
	logic       bank_we    [2];
	bank_addr_t bank_addr  [2];
	acc_t       bank_rdata [2];

	////////////////////
	// Position of the incoming word
	always_comb begin
		if (rp_first) begin
			cur_pix = '0;
			cur_ich = '0;
			cur_och = frame_active ? och_t'(och_cnt + 1'b1) : och_t'(0);
		end else begin
			cur_pix = pix_cnt;
			cur_ich = ich_cnt;
			cur_och = och_cnt;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt      <= '0;
			ich_cnt      <= '0;
			och_cnt      <= '0;
			frame_active <= 1'b0;
		end else if (rp_valid) begin
			pix_cnt <= cur_pix + 1'b1;
			if (cur_pix == pix_idx_t'(img_size - 1)) begin
				ich_cnt <= cur_ich + 1'b1;
			end else begin
				ich_cnt <= cur_ich;
			end
			och_cnt <= cur_och;
			if (rp_first) begin
				frame_active <= 1'b1;
			end
			// Last word of the last pass closes the frame
			if (cur_pix == pix_idx_t'(img_size - 1) && cur_ich == ich_t'(ch_in - 1) &&
			    cur_och == och_t'(ch_out - 1)) begin
				frame_active <= 1'b0;
			end
		end
	end

	assign w_och = cur_och;
	assign w_ich = cur_ich;
	assign prod  = acc_t'(rp_pixel) * acc_t'(w_value);

	////////////////////
	// Stage 1, product and partial-sum read
	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= rp_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_pix  <= cur_pix;
		s1_ich  <= cur_ich;
		s1_och  <= cur_och;
		s1_prod <= prod;
	end

	////////////////////
	// Stage 2, add and write back or emit
	assign psum_rd  = bank_rdata[s1_pix[0]];
	assign sum      = ((s1_ich == '0) ? acc_t'(0) : psum_rd) + s1_prod;
	assign s2_write = s1_valid && (s1_ich != ich_t'(ch_in - 1));

	// Stage 2 and stage 1 hold neighbouring pixels, so they never hit the same bank
	for (genvar b = 0; b < 2; b++) begin : g_bank
		assign bank_we[b]   = s2_write && (s1_pix[0] == b);
		assign bank_en[b]   = bank_we[b] || (rp_valid && cur_pix[0] == b);
		assign bank_addr[b] = bank_we[b] ? s1_pix[$bits(pix_idx_t)-1:1] :
		                                   cur_pix[$bits(pix_idx_t)-1:1];

		fmap_ram #(
			.word_t(acc_t),
			.depth (psum_depth)
		) psum_ram_i (
			.clk  (clk),
			.en   (bank_en[b]),
			.we   (bank_we[b]),
			.addr (bank_addr[b]),
			.wdata(sum),
			.rdata(bank_rdata[b])
		);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= s1_valid && (s1_ich == ich_t'(ch_in - 1));
		end
	end

	always_ff @(posedge clk) begin
		res.och   <= s1_och;
		res.pix   <= s1_pix;
		res.value <= sum;
	end

endmodule

`default_nettype wire

/* hw/conv_layer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer_top import conv_pkg::*; (
	input  wire             clk,
	input  wire             reset,
	input  wire             wr_req,
	input  wire weight_wr_t wr_data,
	output logic            wr_ack,
	input  wire             pxl_valid,
	input  wire pixel_t     pxl_in,
	output logic            res_valid,
	output result_t         res,
	output logic            busy
);

	logic    rp_valid;
	pixel_t  rp_pixel;
	logic    rp_first;
	och_t    w_och;
	ich_t    w_ich;
	weight_t w_value;

	weight_store weight_store_i (
		.clk    (clk),
		.reset  (reset),
		.wr_req (wr_req),
		.wr_data(wr_data),
		.wr_ack (wr_ack),
		.w_och  (w_och),
		.w_ich  (w_ich),
		.w_value(w_value)
	);

	fmap_replay fmap_replay_i (
		.clk      (clk),
		.reset    (reset),
		.pxl_valid(pxl_valid),
		.pxl_in   (pxl_in),
		.rp_valid (rp_valid),
		.rp_pixel (rp_pixel),
		.rp_first (rp_first),
		.busy     (busy)
	);

	pointwise_accum pointwise_accum_i (
		.clk      (clk),
		.reset    (reset),
		.rp_valid (rp_valid),
		.rp_pixel (rp_pixel),
		.rp_first (rp_first),
		.w_och    (w_och),
		.w_ich    (w_ich),
		.w_value  (w_value),
		.res_valid(res_valid),
		.res      (res)
	);

endmodule

`default_nettype wire

/* testbench/tb_conv_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv_layer import conv_pkg::*; ();

	// Cycles for one frame of replay passes, input with gaps and weight loading
	localparam int frame_cycles = ch_out * (fmap_words + gap_cycles) + 2 * fmap_words +
		ch_out * ch_in * 8;
	localparam int watchdog_cycles = 2 * frame_cycles * 2;
	localparam int frame_results = ch_out * img_size;

	logic       clk;
	logic       reset;
	logic       wr_req;
	weight_wr_t wr_data;
	logic       wr_ack;
	logic       pxl_valid;
	pixel_t     pxl_in;
	logic       res_valid;
	result_t    res;
	logic       busy;

	weight_t     w_model [ch_out][ch_in];
	pixel_t      px_model [ch_in][img_size];
	result_t     expected_q [$];
	int          res_count;
	logic [31:0] lfsr_state;
	logic        req_prev;
	logic        ack_prev;

	conv_layer_top dut_i (
		.clk      (clk),
		.reset    (reset),
		.wr_req   (wr_req),
		.wr_data  (wr_data),
		.wr_ack   (wr_ack),
		.pxl_valid(pxl_valid),
		.pxl_in   (pxl_in),
		.res_valid(res_valid),
		.res      (res),
		.busy     (busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(watchdog_cycles * 10);
		$display("The run timed out before all tests finished");
		abort_run();
	end

	////////////////////
	// Random numbers and reference model

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic result_t model_result(input int och, input int pix);
		int      sum;
		result_t r;
		sum = 0;
		for (int c = 0; c < ch_in; c++) begin
			sum += int'(px_model[c][pix]) * int'(w_model[och][c]);
		end
		r.och = och_t'(och);
		r.pix = pix_idx_t'(pix);
		r.value = acc_t'(sum);
		return r;
	endfunction

	////////////////////
	// Checks
	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string field, input int got, input int exp);
		$display("error at %0t ns: %s got %0d, expected %0d (result %0d)",
			$time, field, got, exp, res_count);
		abort_run();
	endtask

	task automatic check_result(input result_t got, input result_t exp);
		if (got.och !== exp.och) begin
			report_mismatch("och", got.och, exp.och);
		end
		if (got.pix !== exp.pix) begin
			report_mismatch("pix", got.pix, exp.pix);
		end
		if (got.value !== exp.value) begin
			report_mismatch("value", got.value, exp.value);
		end
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp) begin
			report_mismatch("result count", got, exp);
		end
	endtask

	// Result stream and ack only ever following a request
	always @(negedge clk) begin
		result_t exp_r;
		if (!reset) begin
			if (wr_ack && !ack_prev && !req_prev) begin
				$display("wr_ack rose although wr_req was low");
				abort_run();
			end
			if (res_valid) begin
				if (expected_q.size() == 0) begin
					$display("A result arrived when none was expected");
					abort_run();
				end else begin
					exp_r = expected_q.pop_front();
					check_result(res, exp_r);
					res_count++;
				end
			end
		end
		req_prev = wr_req;
		ack_prev = wr_ack;
	end

	////////////////////
	// Host weight port
	task automatic wait_ack(input logic level);
		int t;
		t = 0;
		while (wr_ack !== level) begin
			@(negedge clk);
			t++;
			if (t > 8) begin
				$display("wr_ack did not follow wr_req within 8 cycles");
				abort_run();
			end
		end
	endtask

	task automatic write_weight(input weight_wr_t w);
		@(posedge clk);
		wr_req  <= 1'b1;
		wr_data <= w;
		@(negedge clk);
		wait_ack(1'b1);
		@(posedge clk);
		wr_req <= 1'b0;
		@(negedge clk);
		wait_ack(1'b0);
	endtask

	task automatic load_weights();
		weight_wr_t w;
		for (int o = 0; o < ch_out; o++) begin
			for (int c = 0; c < ch_in; c++) begin
				w.och = och_t'(o);
				w.ich = ich_t'(c);
				w.value = weight_t'(rand_bits(8));
				w_model[o][c] = w.value;
				write_weight(w);
			end
		end
	endtask

	////////////////////
	// Frames
	task automatic build_frame();
		for (int c = 0; c < ch_in; c++) begin
			for (int p = 0; p < img_size; p++) begin
				px_model[c][p] = pixel_t'(rand_bits(8));
			end
		end
		for (int o = 0; o < ch_out; o++) begin
			for (int p = 0; p < img_size; p++) begin
				expected_q.push_back(model_result(o, p));
			end
		end
	endtask

	// Channel-major order with valid low on about one cycle in four
	task automatic drive_frame();
		int i;
		i = 0;
		while (i < fmap_words) begin
			@(posedge clk);
			if (rand_bits(2) == 0) begin
				pxl_valid <= 1'b0;
			end else begin
				pxl_valid <= 1'b1;
				pxl_in    <= px_model[i / img_size][i % img_size];
				i++;
			end
		end
		@(posedge clk);
		pxl_valid <= 1'b0;
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
			if (t > frame_cycles) begin
				$display("busy did not fall at the end of the frame");
				abort_run();
			end
		end while (busy);
	endtask

	task automatic wait_results(input int n);
		int t;
		t = 0;
		while (res_count < n) begin
			@(negedge clk);
			t++;
			if (t > frame_cycles) begin
				$display("Results stopped arriving during the frame");
				abort_run();
			end
		end
	endtask

	task automatic check_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if (busy || res_valid) begin
				$display("busy or res_valid went high with no frame in flight");
				abort_run();
			end
		end
	endtask

	task automatic run_frame();
		load_weights();
		build_frame();
		res_count = 0;
		drive_frame();
		wait_idle();
		check_count(res_count, frame_results);
		check_quiet(10);
	endtask

	////////////////////
	// Test sequence
	initial begin
		lfsr_state  = 32'd78131;
		res_count   = 0;
		req_prev    = 1'b0;
		ack_prev    = 1'b0;
		reset       = 1'b1;
		wr_req      = 1'b0;
		wr_data     = '0;
		pxl_valid   = 1'b0;
		pxl_in      = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// The second frame must not see partial sums of the first
		run_frame();
		run_frame();

		// Reset while the second pass replays
		load_weights();
		build_frame();
		res_count = 0;
		drive_frame();
		wait_results(img_size + 6);
		@(posedge clk);
		reset <= 1'b1;
		expected_q.delete();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		check_quiet(20);
		run_frame();

		repeat (5) @(posedge clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hw/conv_pkg.sv
hw/fmap_ram.sv
hw/fmap_replay.sv
hw/weight_store.sv
hw/pointwise_accum.sv
hw/conv_layer_top.sv
testbench/tb_conv_layer.sv

/* Bender.yml */
package:
  name: conv_layer

sources:
  - files:
      - hw/conv_pkg.sv
      - hw/fmap_ram.sv
      - hw/fmap_replay.sv
      - hw/weight_store.sv
      - hw/pointwise_accum.sv
      - hw/conv_layer_top.sv
  - target: test
    files:
      - testbench/tb_conv_layer.sv
